//--- bench/id_stage_vectors.svh
`ifndef ID_STAGE_VECTORS_SVH
`define ID_STAGE_VECTORS_SVH

    // each row is instruction, ex bypass and mem bypass, then the expected
    // alu_op, alu_sel, wreg, waddr, reg1, reg2 and inst_valid
    task automatic load_vectors();
        // immediate logic with the immediate as operand 2
        add_row(enc_i(OP_ANDI, 1, 2, 16'hf0f0), NO_FWD, NO_FWD,
                ALU_AND, SEL_LOGIC, 1'b1, 2, preload_val(1), 32'h0000_f0f0, 1'b1);
        add_row(enc_i(OP_ORI, 3, 4, 16'h8001), NO_FWD, NO_FWD,
                ALU_OR, SEL_LOGIC, 1'b1, 4, preload_val(3), 32'h0000_8001, 1'b1);
        add_row(enc_i(OP_XORI, 5, 6, 16'hffff), NO_FWD, NO_FWD,
                ALU_XOR, SEL_LOGIC, 1'b1, 6, preload_val(5), 32'h0000_ffff, 1'b1);
        add_row(enc_i(OP_LUI, 9, 7, 16'h1234), NO_FWD, NO_FWD,
                ALU_LUI, SEL_LOGIC, 1'b1, 7, preload_val(9), 32'h1234_0000, 1'b1);
        // register logic and variable shifts
        add_row(enc_r(FN_AND, 8, 9, 10, 0), NO_FWD, NO_FWD,
                ALU_AND, SEL_LOGIC, 1'b1, 10, preload_val(8), preload_val(9), 1'b1);
        add_row(enc_r(FN_NOR, 17, 18, 19, 0), NO_FWD, NO_FWD,
                ALU_NOR, SEL_LOGIC, 1'b1, 19, preload_val(17), preload_val(18), 1'b1);
        add_row(enc_r(FN_SLLV, 20, 21, 22, 0), NO_FWD, NO_FWD,
                ALU_SLL, SEL_SHIFT, 1'b1, 22, preload_val(20), preload_val(21), 1'b1);
        // constant shift with shamt in reg1
        add_row(enc_r(FN_SRA, 0, 29, 30, 5), NO_FWD, NO_FWD,
                ALU_SRA, SEL_SHIFT, 1'b1, 30, 32'd5, preload_val(29), 1'b1);
        // hi/lo moves, nonzero unused fields must not be read
        add_row(enc_r(FN_MFHI, 11, 12, 4, 0), NO_FWD, NO_FWD,
                ALU_MFHI, SEL_MOVE, 1'b1, 4, 32'd0, 32'd0, 1'b1);
        add_row(enc_r(FN_MTLO, 6, 12, 0, 0), NO_FWD, NO_FWD,
                ALU_MTLO, SEL_NOP, 1'b0, 0, preload_val(6), 32'd0, 1'b1);
        // forwarding order is ex before mem before register file
        add_row(enc_r(FN_OR, 1, 2, 3, 0),
                fwd(1'b1, 1, 32'heeee_0001), fwd(1'b1, 1, 32'haaaa_0001),
                ALU_OR, SEL_LOGIC, 1'b1, 3, 32'heeee_0001, preload_val(2), 1'b1);
        add_row(enc_r(FN_OR, 1, 2, 3, 0), NO_FWD, fwd(1'b1, 2, 32'haaaa_0002),
                ALU_OR, SEL_LOGIC, 1'b1, 3, preload_val(1), 32'haaaa_0002, 1'b1);
        add_row(enc_r(FN_XOR, 1, 2, 3, 0),
                fwd(1'b0, 1, $random(seed)), fwd(1'b0, 2, $random(seed)),
                ALU_XOR, SEL_LOGIC, 1'b1, 3, preload_val(1), preload_val(2), 1'b1);
        add_row(enc_r(FN_AND, 0, 2, 3, 0), fwd(1'b1, 0, 32'hdead_beef), NO_FWD,
                ALU_AND, SEL_LOGIC, 1'b1, 3, 32'd0, preload_val(2), 1'b1);
        add_row(enc_r(FN_AND, 4, 5, 6, 0),
                fwd(1'b1, 5, 32'h1111_5555), fwd(1'b1, 4, 32'h2222_4444),
                ALU_AND, SEL_LOGIC, 1'b1, 6, 32'h2222_4444, 32'h1111_5555, 1'b1);
        // conditional moves follow the selected rt value
        add_row(enc_r(FN_MOVN, 1, 2, 3, 0), NO_FWD, NO_FWD,
                ALU_MOVN, SEL_MOVE, 1'b1, 3, preload_val(1), preload_val(2), 1'b1);
        add_row(enc_r(FN_MOVN, 1, 0, 3, 0), NO_FWD, NO_FWD,
                ALU_MOVN, SEL_MOVE, 1'b0, 3, preload_val(1), 32'd0, 1'b1);
        add_row(enc_r(FN_MOVZ, 1, 0, 3, 0), NO_FWD, NO_FWD,
                ALU_MOVZ, SEL_MOVE, 1'b1, 3, preload_val(1), 32'd0, 1'b1);
        add_row(enc_r(FN_MOVN, 1, 2, 3, 0), fwd(1'b1, 2, 32'd0), NO_FWD,
                ALU_MOVN, SEL_MOVE, 1'b0, 3, preload_val(1), 32'd0, 1'b1);
        add_row(enc_r(FN_MOVZ, 1, 2, 3, 0), NO_FWD, fwd(1'b1, 2, 32'd0),
                ALU_MOVZ, SEL_MOVE, 1'b1, 3, preload_val(1), 32'd0, 1'b1);
        // lw is not kept, so it decodes as invalid
        add_row(enc_i(6'b100011, 1, 2, 16'h0004), NO_FWD, NO_FWD,
                ALU_NOP, SEL_NOP, 1'b0, 0, 32'd0, 32'd0, 1'b0);
        add_row(enc_r(FN_AND, 1, 2, 0, 1), NO_FWD, NO_FWD,
                ALU_NOP, SEL_NOP, 1'b0, 0, 32'd0, 32'd0, 1'b0);
    endtask

`endif

//--- bench/tb_id_stage.sv
`default_nettype none

module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;
    import id_stage_pkg::*;

    typedef struct packed {
        inst_t    inst;
        wr_port_t ex_fwd;
        wr_port_t mem_fwd;
        id_ex_t   exp;
    } vector_t;

    localparam wr_port_t NO_FWD = '0;

    logic     clk;
    logic     reset_i;
    word_t    pc_i;
    inst_t    inst_i;
    wr_port_t ex_fwd_i;
    wr_port_t mem_fwd_i;
    wr_port_t wb_i;
    id_ex_t   id_ex_o;

    vector_t vectors[$];
    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;
    int      cycle_limit;
    integer  seed = 32'h21cd;

    id_stage UUT (
        .clk       (clk),
        .reset_i   (reset_i),
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_i      (wb_i),
        .id_ex_o   (id_ex_o)
    );

    // value written to register r during preload
    function automatic word_t preload_val(input int r);
        return (r == 0) ? 32'd0 : word_t'(r) * 32'h0101_0101 + 32'd5;
    endfunction

    function automatic inst_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic inst_t enc_r(input logic [5:0] fn, input int rs, input int rt,
                                    input int rd, input int sa);
        return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic wr_port_t fwd(input logic we, input int addr, input word_t data);
        return '{we: we, addr: 5'(addr), data: data};
    endfunction

    task automatic add_row(input inst_t inst, input wr_port_t ex, input wr_port_t mem,
                           input alu_op_e op, input alu_sel_e sel, input logic wreg,
                           input int waddr, input word_t reg1, input word_t reg2,
                           input logic valid);
        vector_t v;
        v.inst    = inst;
        v.ex_fwd  = ex;
        v.mem_fwd = mem;
        v.exp     = '{alu_op: op, alu_sel: sel, wreg: wreg, waddr: 5'(waddr),
                      reg1: reg1, reg2: reg2, inst_valid: valid};
        vectors.push_back(v);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_output(input string tag, input id_ex_t got, input id_ex_t exp);
        check_value({tag, " alu_op"}, 32'(got.alu_op), 32'(exp.alu_op));
        check_value({tag, " alu_sel"}, 32'(got.alu_sel), 32'(exp.alu_sel));
        check_value({tag, " wreg"}, 32'(got.wreg), 32'(exp.wreg));
        check_value({tag, " waddr"}, 32'(got.waddr), 32'(exp.waddr));
        check_value({tag, " reg1"}, got.reg1, exp.reg1);
        check_value({tag, " reg2"}, got.reg2, exp.reg2);
        check_value({tag, " inst_valid"}, 32'(got.inst_valid), 32'(exp.inst_valid));
    endtask

    `include "id_stage_vectors.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        reset_i     = 1'b1;
        pc_i        = 32'h0000_1000;
        inst_i      = enc_i(OP_ORI, 1, 2, 16'h00ff);  // valid op, masked by reset
        ex_fwd_i    = fwd(1'b1, 1, 32'hffff_ffff);
        mem_fwd_i   = NO_FWD;
        wb_i        = NO_FWD;
        load_vectors();
        cycle_limit = 8 + 31 + vectors.size() + 20;

        // nop with zero operands while in reset
        repeat (7) @(posedge clk);
        #80;
        check_output("reset", id_ex_o, '{alu_op: ALU_NOP, alu_sel: SEL_NOP, wreg: 1'b0,
                     waddr: 5'd0, reg1: 32'd0, reg2: 32'd0, inst_valid: 1'b0});
        @(posedge clk);
        #10;
        reset_i  = 1'b0;
        ex_fwd_i = NO_FWD;

        for (int r = 1; r < NUM_REGS; r++) begin
            wb_i = fwd(1'b1, r, preload_val(r));
            @(posedge clk);
            #10;
        end
        wb_i = NO_FWD;

        foreach (vectors[i]) begin
            inst_i    = vectors[i].inst;
            ex_fwd_i  = vectors[i].ex_fwd;
            mem_fwd_i = vectors[i].mem_fwd;
            pc_i      = pc_i + 32'd4;
            #80;  // just before the next edge
            check_output($sformatf("row %0d", i), id_ex_o, vectors[i].exp);
            @(posedge clk);
            #10;
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/id_stage.sv
`default_nettype none

module id_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  mips_isa_pkg::word_t    pc_i,       // kept for the later branch stage
    input  mips_isa_pkg::inst_t    inst_i,
    input  id_stage_pkg::wr_port_t ex_fwd_i,
    input  id_stage_pkg::wr_port_t mem_fwd_i,
    input  id_stage_pkg::wr_port_t wb_i,
    output id_stage_pkg::id_ex_t   id_ex_o
);
    import mips_isa_pkg::*;
    import id_stage_pkg::*;

    rd_req_t rd1_req;
    rd_req_t rd2_req;
    word_t   imm;
    word_t   rf_rd1;
    word_t   rf_rd2;
    word_t   reg1;
    word_t   reg2;
    id_ex_t  ctrl;

    inst_decoder u_dec (
        .reset_i    (reset_i),
        .inst_i     (inst_i),
        .reg2_val_i (reg2),       // movn/movz look at the forwarded rt
        .rd1_req_o  (rd1_req),
        .rd2_req_o  (rd2_req),
        .imm_o      (imm),
        .ctrl_o     (ctrl)
    );

    operand_select u_sel1 (
        .reset_i   (reset_i),
        .req_i     (rd1_req),
        .imm_i     (imm),
        .rf_data_i (rf_rd1),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg1)
    );

    operand_select u_sel2 (
        .reset_i   (reset_i),
        .req_i     (rd2_req),
        .imm_i     (imm),
        .rf_data_i (rf_rd2),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg2)
    );

    regfile u_rf (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd1_addr_i (rd1_req.addr),
        .rd2_addr_i (rd2_req.addr),
        .rd1_data_o (rf_rd1),
        .rd2_data_o (rf_rd2),
        .wb_i       (wb_i)
    );

    // decoder control plus the two fetched operands
    always_comb begin
        id_ex_o      = ctrl;
        id_ex_o.reg1 = reg1;
        id_ex_o.reg2 = reg2;
    end

    a_invalid_no_write: assert property (@(posedge clk) disable iff (reset_i)
        !id_ex_o.inst_valid |-> !id_ex_o.wreg)
        else $error("invalid instruction requests a register write");

    // immediate reaches operand 2 whenever rt is not read
    a_imm_pass: assert property (@(posedge clk) disable iff (reset_i)
        !rd2_req.en |-> id_ex_o.reg2 == imm)
        else $error("operand 2 differs from the immediate");

endmodule

`default_nettype wire

//--- design/id_stage_pkg.sv
`default_nettype none

package id_stage_pkg;

    // operation codes seen by execute
    typedef enum logic [7:0] {
        ALU_NOP  = 8'b0000_0000,
        ALU_AND  = 8'b0010_0100,
        ALU_OR   = 8'b0010_0101,
        ALU_XOR  = 8'b0010_0110,
        ALU_NOR  = 8'b0010_0111,
        ALU_LUI  = 8'b0101_1100,
        ALU_SLL  = 8'b0111_1100,
        ALU_SRL  = 8'b0000_0010,
        ALU_SRA  = 8'b0000_0011,
        ALU_MFHI = 8'b0001_0000,
        ALU_MFLO = 8'b0001_0010,
        ALU_MTHI = 8'b0001_0001,
        ALU_MTLO = 8'b0001_0011,
        ALU_MOVN = 8'b0000_1011,
        ALU_MOVZ = 8'b0000_1010
    } alu_op_e;

    // result class, picks the execute result mux
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011
    } alu_sel_e;

    // a register write, as a bypass or as the writeback port
    typedef struct packed {
        logic                    we;
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::word_t     data;
    } wr_port_t;

    // one source operand read request
    typedef struct packed {
        logic                    en;
        mips_isa_pkg::reg_addr_t addr;
    } rd_req_t;

    // decoded micro-op toward execute
    typedef struct packed {
        alu_op_e                 alu_op;
        alu_sel_e                alu_sel;
        logic                    wreg;        // write the destination
        mips_isa_pkg::reg_addr_t waddr;
        mips_isa_pkg::word_t     reg1;
        mips_isa_pkg::word_t     reg2;
        logic                    inst_valid;
    } id_ex_t;

endpackage

`default_nettype wire

//--- design/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  logic                  reset_i,
    input  mips_isa_pkg::inst_t   inst_i,
    input  mips_isa_pkg::word_t   reg2_val_i,  // selected operand 2, for movn/movz
    output id_stage_pkg::rd_req_t rd1_req_o,
    output id_stage_pkg::rd_req_t rd2_req_o,
    output mips_isa_pkg::word_t   imm_o,
    output id_stage_pkg::id_ex_t  ctrl_o
);
    import mips_isa_pkg::*;
    import id_stage_pkg::*;

    logic [IMM_W-1:0] imm16;
    id_ex_t           ctrl;
    logic             cond_nz;  // movn, write if rt nonzero
    logic             cond_z;   // movz, write if rt zero

    assign imm16 = {inst_i.rd, inst_i.shamt, inst_i.funct};

    always_comb begin
        // bubble unless a known encoding matches
        ctrl.alu_op     = ALU_NOP;
        ctrl.alu_sel    = SEL_NOP;
        ctrl.wreg       = 1'b0;
        ctrl.waddr      = inst_i.rd;
        ctrl.reg1       = '0;
        ctrl.reg2       = '0;
        ctrl.inst_valid = 1'b0;
        rd1_req_o       = '{en: 1'b0, addr: inst_i.rs};
        rd2_req_o       = '{en: 1'b0, addr: inst_i.rt};
        imm_o           = '0;
        cond_nz         = 1'b0;
        cond_z          = 1'b0;

        if (reset_i) begin
            ctrl.waddr     = '0;
            rd1_req_o.addr = '0;
            rd2_req_o.addr = '0;
        end else begin
            case (inst_i.opcode)
                OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    ctrl.alu_sel    = SEL_LOGIC;
                    ctrl.wreg       = 1'b1;
                    ctrl.waddr      = inst_i.rt;   // i-format writes rt
                    ctrl.inst_valid = 1'b1;
                    rd1_req_o.en    = 1'b1;
                    imm_o           = {{(DATA_W-IMM_W){1'b0}}, imm16};
                    case (inst_i.opcode)
                        OP_ANDI: ctrl.alu_op = ALU_AND;
                        OP_ORI:  ctrl.alu_op = ALU_OR;
                        OP_XORI: ctrl.alu_op = ALU_XOR;
                        default: begin
                            ctrl.alu_op = ALU_LUI;
                            imm_o       = {imm16, {(DATA_W-IMM_W){1'b0}}};  // upper half
                        end
                    endcase
                end
                OP_SPECIAL: begin
                    case (inst_i.funct)
                        FN_SLL, FN_SRL, FN_SRA: begin
                            // constant shifts need rs == 0
                            if (inst_i.rs == '0) begin
                                ctrl.alu_sel    = SEL_SHIFT;
                                ctrl.wreg       = 1'b1;
                                ctrl.inst_valid = 1'b1;
                                rd2_req_o.en    = 1'b1;  // value to shift from rt
                                imm_o = {{(DATA_W-SHAMT_W){1'b0}}, inst_i.shamt};
                                case (inst_i.funct)
                                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                                    default: ctrl.alu_op = ALU_SRA;
                                endcase
                            end
                        end
                        default: begin
                            // register forms, shamt must be zero
                            if (inst_i.shamt == '0) begin
                                case (inst_i.funct)
                                    FN_AND, FN_OR, FN_XOR, FN_NOR,
                                    FN_SLLV, FN_SRLV, FN_SRAV: begin
                                        ctrl.wreg       = 1'b1;
                                        ctrl.inst_valid = 1'b1;
                                        rd1_req_o.en    = 1'b1;
                                        rd2_req_o.en    = 1'b1;
                                        ctrl.alu_sel    = SEL_LOGIC;
                                        case (inst_i.funct)
                                            FN_AND: ctrl.alu_op = ALU_AND;
                                            FN_OR:  ctrl.alu_op = ALU_OR;
                                            FN_XOR: ctrl.alu_op = ALU_XOR;
                                            FN_NOR: ctrl.alu_op = ALU_NOR;
                                            default: begin
                                                ctrl.alu_sel = SEL_SHIFT;  // amount in rs
                                                if (inst_i.funct == FN_SLLV) begin
                                                    ctrl.alu_op = ALU_SLL;
                                                end else if (inst_i.funct == FN_SRLV) begin
                                                    ctrl.alu_op = ALU_SRL;
                                                end else begin
                                                    ctrl.alu_op = ALU_SRA;
                                                end
                                            end
                                        endcase
                                    end
                                    FN_MFHI, FN_MFLO: begin
                                        ctrl.alu_sel    = SEL_MOVE;
                                        ctrl.wreg       = 1'b1;
                                        ctrl.inst_valid = 1'b1;
                                        ctrl.alu_op = (inst_i.funct == FN_MFHI) ? ALU_MFHI
                                                                                : ALU_MFLO;
                                    end
                                    FN_MTHI, FN_MTLO: begin
                                        // only hi/lo change, no gpr write
                                        ctrl.inst_valid = 1'b1;
                                        rd1_req_o.en    = 1'b1;
                                        ctrl.alu_op = (inst_i.funct == FN_MTHI) ? ALU_MTHI
                                                                                : ALU_MTLO;
                                    end
                                    FN_MOVN, FN_MOVZ: begin
                                        ctrl.alu_sel    = SEL_MOVE;
                                        ctrl.inst_valid = 1'b1;
                                        rd1_req_o.en    = 1'b1;
                                        rd2_req_o.en    = 1'b1;
                                        if (inst_i.funct == FN_MOVN) begin
                                            ctrl.alu_op = ALU_MOVN;
                                            cond_nz     = 1'b1;
                                        end else begin
                                            ctrl.alu_op = ALU_MOVZ;
                                            cond_z      = 1'b1;
                                        end
                                    end
                                    default: ;  // unknown funct, stays a bubble
                                endcase
                            end
                        end
                    endcase
                end
                default: ;  // unknown opcode
            endcase
        end
    end

    // conditional move write decision on the forwarded rt value
    always_comb begin
        ctrl_o = ctrl;
        if (cond_nz) begin
            ctrl_o.wreg = (reg2_val_i != '0);
        end else if (cond_z) begin
            ctrl_o.wreg = (reg2_val_i == '0);
        end
    end

endmodule

`default_nettype wire

//--- design/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // field widths of the 32-bit MIPS encoding
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;
    localparam int SHAMT_W    = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // R-format view of an instruction
    // the I-format immediate is {rd, shamt, funct}
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;  // bits 31:26
        reg_addr_t           rs;      // bits 25:21
        reg_addr_t           rt;      // bits 20:16
        reg_addr_t           rd;      // bits 15:11
        logic [SHAMT_W-1:0]  shamt;   // bits 10:6
        logic [FUNCT_W-1:0]  funct;   // bits 5:0
    } inst_t;

    // primary opcodes
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000,  // R-type, decoded by funct
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // funct codes under OP_SPECIAL
    typedef enum logic [FUNCT_W-1:0] {
        // constant shifts, amount in shamt
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,

        // variable shifts, amount in rs
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,

        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,

        // hi/lo moves
        FN_MFHI = 6'b010000,
        FN_MTHI = 6'b010001,
        FN_MFLO = 6'b010010,
        FN_MTLO = 6'b010011,

        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111
    } funct_e;

endpackage

`default_nettype wire

//--- design/operand_select.sv
`default_nettype none

module operand_select (
    input  logic                   reset_i,
    input  id_stage_pkg::rd_req_t  req_i,
    input  mips_isa_pkg::word_t    imm_i,
    input  mips_isa_pkg::word_t    rf_data_i,
    input  id_stage_pkg::wr_port_t ex_fwd_i,
    input  id_stage_pkg::wr_port_t mem_fwd_i,
    output mips_isa_pkg::word_t    operand_o
);

    logic ex_hit;
    logic mem_hit;

    // a bypass counts only when it writes the register being read
    assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.addr == req_i.addr);
    assign mem_hit = mem_fwd_i.we && (mem_fwd_i.addr == req_i.addr);

    always_comb begin
        if (reset_i) begin
            operand_o = '0;
        end else if (!req_i.en) begin
            operand_o = imm_i;          // no register source, pass the immediate
        end else if (req_i.addr == '0) begin
            operand_o = '0;             // r0 is hardwired, never forwarded
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.data;  // newest result first
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

//--- design/regfile.sv
`default_nettype none

module regfile (
    input  logic                   clk,
    input  logic                   reset_i,
    input  mips_isa_pkg::reg_addr_t rd1_addr_i,
    input  mips_isa_pkg::reg_addr_t rd2_addr_i,
    output mips_isa_pkg::word_t    rd1_data_o,
    output mips_isa_pkg::word_t    rd2_data_o,
    input  id_stage_pkg::wr_port_t wb_i
);
    import mips_isa_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.addr != '0)) begin
            regs[wb_i.addr] <= wb_i.data;  // r0 writes dropped
        end
    end

    // combinational reads
    // a same-cycle write is not seen here, the bypass covers it
    assign rd1_data_o = regs[rd1_addr_i];
    assign rd2_data_o = regs[rd2_addr_i];

    a_r0_zero: assert property (@(posedge clk) disable iff (reset_i)
        regs[0] == '0)
        else $error("register 0 holds a nonzero value");

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
design/mips_isa_pkg.sv
design/id_stage_pkg.sv
design/inst_decoder.sv
design/operand_select.sv
design/regfile.sv
design/id_stage.sv
bench/tb_id_stage.sv
